//--- source/axil_pkg.sv
/*
 * AXI4-Lite bus widths and response codes
 * shared by the CLINT slave port and its testbench
 */
`default_nettype none

package axil_pkg;

	// one 32-bit word per beat
	localparam int unsigned AXIL_DATA_W = 32;
	localparam int unsigned AXIL_STRB_W = AXIL_DATA_W / 8;

	// xRESP field of the b and r channels
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY   = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- source/clint_pkg.sv
/*
 * CLINT register map: local offsets, register selector
 * and reset values of the timer and delay registers
 */
`default_nettype none

package clint_pkg;

	// offset inside the CLINT window
	localparam int unsigned CLINT_ADDR_W = 16;

	localparam logic [CLINT_ADDR_W-1:0] OFF_MSIP        = 16'h0000;
	localparam logic [CLINT_ADDR_W-1:0] OFF_MTIMECMP_LO = 16'h4000;
	localparam logic [CLINT_ADDR_W-1:0] OFF_MTIMECMP_HI = 16'h4004;
	localparam logic [CLINT_ADDR_W-1:0] OFF_MTIME_LO    = 16'hBFF8;
	localparam logic [CLINT_ADDR_W-1:0] OFF_MTIME_HI    = 16'hBFFC;

	// compare at the top of the range, no timer irq out of reset
	localparam logic [63:0] MTIMECMP_RESET = {64{1'b1}};

	// bit 0 set, so any truncated seed stays nonzero
	localparam logic [15:0] DELAY_SEED_RESET = 16'hACE1;

	typedef enum logic [2:0] {
		REG_MSIP,
		REG_MTIMECMP_LO,
		REG_MTIMECMP_HI,
		REG_MTIME_LO,
		REG_MTIME_HI,
		REG_NONE
	} clint_reg_e;

endpackage

`default_nettype wire

//--- source/clint_delay_lfsr.sv
/*
 * Fibonacci LFSR drawing the pseudo-random response delay
 */
`timescale 1ns/1ps
`default_nettype none

module clint_delay_lfsr
	import clint_pkg::*;
#(
	// widths 2..16 have a tap set below
	parameter int unsigned      WIDTH = 6,
	parameter logic [WIDTH-1:0] SEED  = DELAY_SEED_RESET[WIDTH-1:0]
) (
	input  logic             clock_i,
	input  logic             rstn_i,
	input  logic             adv_i,
	output logic [WIDTH-1:0] delay_o
);

	// maximal-length tap masks, bit n-1 for tap n
	function automatic logic [15:0] tap_mask(input int unsigned w);
		case (w)
			2:       return 16'h0003;
			3:       return 16'h0006;
			4:       return 16'h000C;
			5:       return 16'h0014;
			6:       return 16'h0030;
			7:       return 16'h0060;
			8:       return 16'h00B8;
			9:       return 16'h0110;
			10:      return 16'h0240;
			11:      return 16'h0500;
			12:      return 16'h0829;
			13:      return 16'h100D;
			14:      return 16'h2015;
			15:      return 16'h6000;
			16:      return 16'hD008;
			default: return 16'h0000;
		endcase
	endfunction

	localparam logic [15:0] TAPS = tap_mask(WIDTH);

	logic [WIDTH-1:0] lfsr_q;
	logic             fb;

	assign fb = ^(lfsr_q & TAPS[WIDTH-1:0]);

	// seed must be nonzero or the register locks up
	always_ff @(posedge clock_i) begin
		if (rstn_i)
			lfsr_q <= SEED;
		else if (adv_i)
			lfsr_q <= {lfsr_q[WIDTH-2:0], fb};
	end

	assign delay_o = lfsr_q;

endmodule

`default_nettype wire

//--- source/clint_regs.sv
/*
 * CLINT registers: mtime counter, mtimecmp, msip
 * offset decode, read mux and interrupt lines
 */
`timescale 1ns/1ps
`default_nettype none

module clint_regs
	import axil_pkg::*;
	import clint_pkg::*;
(
	input  logic                    clock_i,
	input  logic                    rstn_i,
	input  logic [CLINT_ADDR_W-1:0] addr_i,
	input  logic                    wr_en_i,
	input  logic [AXIL_DATA_W-1:0]  wdata_i,
	input  logic [AXIL_STRB_W-1:0]  wstrb_i,
	output clint_reg_e              reg_sel_o,
	output logic [AXIL_DATA_W-1:0]  rdata_o,
	output logic                    mtip_o,
	output logic                    msip_o
);

	localparam int unsigned W = AXIL_DATA_W;

	clint_reg_e      reg_sel;
	logic [2*W-1:0]  mtime_q;
	logic [2*W-1:0]  mtimecmp_q;
	logic            msip_q;

	function automatic logic [W-1:0] apply_strb(
		input logic [W-1:0]           old_val,
		input logic [W-1:0]           new_val,
		input logic [AXIL_STRB_W-1:0] strb
	);
		logic [W-1:0] res;
		res = old_val;
		for (int i = 0; i < AXIL_STRB_W; i++) begin
			if (strb[i])
				res[8*i +: 8] = new_val[8*i +: 8];
		end
		return res;
	endfunction

	always_comb begin
		case (addr_i)
			OFF_MSIP:        reg_sel = REG_MSIP;
			OFF_MTIMECMP_LO: reg_sel = REG_MTIMECMP_LO;
			OFF_MTIMECMP_HI: reg_sel = REG_MTIMECMP_HI;
			OFF_MTIME_LO:    reg_sel = REG_MTIME_LO;
			OFF_MTIME_HI:    reg_sel = REG_MTIME_HI;
			default:         reg_sel = REG_NONE;
		endcase
	end

	assign reg_sel_o = reg_sel;

	// a write to one half freezes the counter for that edge
	always_ff @(posedge clock_i) begin
		if (rstn_i)
			mtime_q <= '0;
		else if (wr_en_i && reg_sel == REG_MTIME_LO)
			mtime_q[W-1:0] <= apply_strb(mtime_q[W-1:0], wdata_i, wstrb_i);
		else if (wr_en_i && reg_sel == REG_MTIME_HI)
			mtime_q[2*W-1:W] <= apply_strb(mtime_q[2*W-1:W], wdata_i, wstrb_i);
		else
			mtime_q <= mtime_q + 1'b1;
	end

	always_ff @(posedge clock_i) begin
		if (rstn_i) begin
			mtimecmp_q <= MTIMECMP_RESET;
		end else if (wr_en_i) begin
			if (reg_sel == REG_MTIMECMP_LO)
				mtimecmp_q[W-1:0] <= apply_strb(mtimecmp_q[W-1:0], wdata_i, wstrb_i);
			if (reg_sel == REG_MTIMECMP_HI)
				mtimecmp_q[2*W-1:W] <= apply_strb(mtimecmp_q[2*W-1:W], wdata_i, wstrb_i);
		end
	end

	// only bit 0 of msip is implemented
	always_ff @(posedge clock_i) begin
		if (rstn_i)
			msip_q <= 1'b0;
		else if (wr_en_i && reg_sel == REG_MSIP && wstrb_i[0])
			msip_q <= wdata_i[0];
	end

	always_comb begin
		case (reg_sel)
			REG_MSIP:        rdata_o = {{(W-1){1'b0}}, msip_q};
			REG_MTIMECMP_LO: rdata_o = mtimecmp_q[W-1:0];
			REG_MTIMECMP_HI: rdata_o = mtimecmp_q[2*W-1:W];
			REG_MTIME_LO:    rdata_o = mtime_q[W-1:0];
			REG_MTIME_HI:    rdata_o = mtime_q[2*W-1:W];
			default:         rdata_o = '0;
		endcase
	end

	assign mtip_o = (mtime_q >= mtimecmp_q);
	assign msip_o = msip_q;

endmodule

`default_nettype wire

//--- source/clint_bus_ctrl.sv
/*
 * AXI4-Lite slave control for the CLINT
 * write/read arbitration, response delay and response hold
 */
`timescale 1ns/1ps
`default_nettype none

module clint_bus_ctrl
	import axil_pkg::*;
	import clint_pkg::*;
#(
	parameter bit           DELAY_EN  = 1'b1,
	parameter int unsigned  MAX_DELAY = 7,
	localparam int unsigned DLY_W     = $clog2(MAX_DELAY + 1)
) (
	input  logic                    clock_i,
	input  logic                    rstn_i,

	input  logic                    awvalid_i,
	output logic                    awready_o,
	input  logic [CLINT_ADDR_W-1:0] awaddr_i,
	input  logic                    wvalid_i,
	output logic                    wready_o,
	input  logic [AXIL_DATA_W-1:0]  wdata_i,
	input  logic [AXIL_STRB_W-1:0]  wstrb_i,
	output logic                    bvalid_o,
	input  logic                    bready_i,
	output axil_resp_t              bresp_o,

	input  logic                    arvalid_i,
	output logic                    arready_o,
	input  logic [CLINT_ADDR_W-1:0] araddr_i,
	output logic                    rvalid_o,
	input  logic                    rready_i,
	output logic [AXIL_DATA_W-1:0]  rdata_o,
	output axil_resp_t              rresp_o,

	// register block side
	output logic [CLINT_ADDR_W-1:0] addr_o,
	output logic                    wr_en_o,
	output logic [AXIL_DATA_W-1:0]  wdata_o,
	output logic [AXIL_STRB_W-1:0]  wstrb_o,
	input  logic [AXIL_DATA_W-1:0]  rdata_i,
	input  clint_reg_e              reg_sel_i,

	input  logic [DLY_W-1:0]        delay_i,
	output logic                    delay_adv_o
);

	typedef enum logic [1:0] {IDLE, DELAY, BRESP, RRESP} state_e;

	state_e                 state_q;
	state_e                 state_d;
	logic                   is_wr_q;
	logic [DLY_W-1:0]       cnt_q;
	logic [DLY_W-1:0]       delay_draw;
	logic                   wr_go;
	logic                   rd_go;
	logic                   accept;
	logic [AXIL_DATA_W-1:0] rdata_q;
	axil_resp_t             resp_q;

	// writes need both aw and w, and win over a pending read
	assign wr_go     = (state_q == IDLE) && !rstn_i && awvalid_i && wvalid_i;
	assign arready_o = (state_q == IDLE) && !rstn_i && !awvalid_i && !wvalid_i;
	assign rd_go     = arready_o && arvalid_i;
	assign accept    = wr_go || rd_go;

	assign awready_o = wr_go;
	assign wready_o  = wr_go;

	// register block sees the offset of the channel being accepted
	assign addr_o      = wr_go ? awaddr_i : araddr_i;
	assign wr_en_o     = wr_go;
	assign wdata_o     = wdata_i;
	assign wstrb_o     = wstrb_i;
	assign delay_adv_o = accept;

	// masking keeps the draw within 0..MAX_DELAY
	assign delay_draw = DELAY_EN ? (delay_i & DLY_W'(MAX_DELAY)) : '0;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (accept) begin
					if (delay_draw != '0)
						state_d = DELAY;
					else if (wr_go)
						state_d = BRESP;
					else
						state_d = RRESP;
				end
			end
			DELAY: begin
				if (cnt_q == DLY_W'(1))
					state_d = is_wr_q ? BRESP : RRESP;
			end
			BRESP: begin
				if (bready_i)
					state_d = IDLE;
			end
			RRESP: begin
				if (rready_i)
					state_d = IDLE;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (rstn_i) begin
			state_q <= IDLE;
			is_wr_q <= 1'b0;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			if (accept) begin
				is_wr_q <= wr_go;
				cnt_q   <= delay_draw;
			end else if (state_q == DELAY) begin
				cnt_q <= cnt_q - DLY_W'(1);
			end
		end
	end

	// response and read data are frozen at accept
	always_ff @(posedge clock_i) begin
		if (accept)
			resp_q <= (reg_sel_i == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
		if (rd_go)
			rdata_q <= rdata_i;
	end

	assign bvalid_o = (state_q == BRESP);
	assign bresp_o  = resp_q;
	assign rvalid_o = (state_q == RRESP);
	assign rresp_o  = resp_q;
	assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

//--- source/clint_top.sv
/*
 * CLINT top level: bus control, register block
 * and response-delay LFSR
 */
`timescale 1ns/1ps
`default_nettype none

module clint_top
	import axil_pkg::*;
	import clint_pkg::*;
#(
	parameter bit          DELAY_EN  = 1'b1,
	parameter int unsigned MAX_DELAY = 7,
	parameter logic [15:0] LFSR_SEED = DELAY_SEED_RESET
) (
	input  logic                    clock_i,
	input  logic                    rstn_i,

	input  logic                    awvalid_i,
	output logic                    awready_o,
	input  logic [CLINT_ADDR_W-1:0] awaddr_i,
	input  logic                    wvalid_i,
	output logic                    wready_o,
	input  logic [AXIL_DATA_W-1:0]  wdata_i,
	input  logic [AXIL_STRB_W-1:0]  wstrb_i,
	output logic                    bvalid_o,
	input  logic                    bready_i,
	output axil_resp_t              bresp_o,

	input  logic                    arvalid_i,
	output logic                    arready_o,
	input  logic [CLINT_ADDR_W-1:0] araddr_i,
	output logic                    rvalid_o,
	input  logic                    rready_i,
	output logic [AXIL_DATA_W-1:0]  rdata_o,
	output axil_resp_t              rresp_o,

	output logic                    mtip_o,
	output logic                    msip_o
);

	localparam int unsigned DLY_W  = $clog2(MAX_DELAY + 1);
	// spare bits let the masked low bits come out as zero too
	localparam int unsigned LFSR_W = DLY_W + 3;

	logic [CLINT_ADDR_W-1:0] addr;
	logic                    wr_en;
	logic [AXIL_DATA_W-1:0]  wdata;
	logic [AXIL_STRB_W-1:0]  wstrb;
	logic [AXIL_DATA_W-1:0]  rdata;
	clint_reg_e              reg_sel;
	logic [LFSR_W-1:0]       lfsr_val;
	logic                    delay_adv;

	clint_bus_ctrl #(
		.DELAY_EN  (DELAY_EN),
		.MAX_DELAY (MAX_DELAY)
	) ctrl_i (
		.clock_i     (clock_i),
		.rstn_i      (rstn_i),
		.awvalid_i   (awvalid_i),
		.awready_o   (awready_o),
		.awaddr_i    (awaddr_i),
		.wvalid_i    (wvalid_i),
		.wready_o    (wready_o),
		.wdata_i     (wdata_i),
		.wstrb_i     (wstrb_i),
		.bvalid_o    (bvalid_o),
		.bready_i    (bready_i),
		.bresp_o     (bresp_o),
		.arvalid_i   (arvalid_i),
		.arready_o   (arready_o),
		.araddr_i    (araddr_i),
		.rvalid_o    (rvalid_o),
		.rready_i    (rready_i),
		.rdata_o     (rdata_o),
		.rresp_o     (rresp_o),
		.addr_o      (addr),
		.wr_en_o     (wr_en),
		.wdata_o     (wdata),
		.wstrb_o     (wstrb),
		.rdata_i     (rdata),
		.reg_sel_i   (reg_sel),
		.delay_i     (lfsr_val[DLY_W-1:0]),
		.delay_adv_o (delay_adv)
	);

	clint_regs regs_i (
		.clock_i   (clock_i),
		.rstn_i    (rstn_i),
		.addr_i    (addr),
		.wr_en_i   (wr_en),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.reg_sel_o (reg_sel),
		.rdata_o   (rdata),
		.mtip_o    (mtip_o),
		.msip_o    (msip_o)
	);

	clint_delay_lfsr #(
		.WIDTH (LFSR_W),
		.SEED  (LFSR_SEED[LFSR_W-1:0])
	) lfsr_i (
		.clock_i (clock_i),
		.rstn_i  (rstn_i),
		.adv_i   (delay_adv),
		.delay_o (lfsr_val)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
/*
 * testbench clock and active-high reset
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int unsigned PERIOD_NS    = 4,
	parameter int unsigned RESET_CYCLES = 8
) (
	output logic clock_o,
	output logic rstn_o
);

	initial begin
		clock_o = 1'b0;
		forever #(PERIOD_NS / 2) clock_o = ~clock_o;
	end

	// released 1 ns after an edge, like the other stimulus
	initial begin
		rstn_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock_o);
		#1;
		rstn_o = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/clint_tb.sv
/*
 * CLINT testbench: AXI4-Lite read/write tasks, register
 * and interrupt checks, protocol assertions, reporting
 */
`timescale 1ns/1ps
`default_nettype none

module clint_tb
	import axil_pkg::*;
	import clint_pkg::*;
();

	localparam int unsigned MAX_DELAY      = 7;
	localparam int unsigned TIMEOUT_CYCLES = 6 * 20 * (MAX_DELAY + 16 + 4);
	localparam logic [31:0] CMP_BASE       = 32'h0010_0000;
	localparam int unsigned CMP_STEPS      = 40;

	logic                    clock;
	logic                    rstn;
	logic                    awvalid;
	logic                    wvalid;
	logic                    bready;
	logic                    arvalid;
	logic                    rready;
	logic                    awready;
	logic                    wready;
	logic                    bvalid;
	logic                    arready;
	logic                    rvalid;
	logic [CLINT_ADDR_W-1:0] awaddr;
	logic [CLINT_ADDR_W-1:0] araddr;
	logic [AXIL_DATA_W-1:0]  wdata;
	logic [AXIL_STRB_W-1:0]  wstrb;
	logic [AXIL_DATA_W-1:0]  rdata;
	axil_resp_t              bresp;
	axil_resp_t              rresp;
	logic                    mtip;
	logic                    msip;

	int unsigned cycle        = 0;
	int unsigned errors       = 0;
	int unsigned errs_at_test = 0;
	int unsigned tests_passed = 0;
	int unsigned tests_failed = 0;
	string       cur_test     = "reset";
	bit          poke_en      = 1'b0;

	tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(8)) clk_gen_i (
		.clock_o (clock),
		.rstn_o  (rstn)
	);

	clint_top #(.DELAY_EN(1'b1), .MAX_DELAY(MAX_DELAY)) dut_i (
		.clock_i   (clock),
		.rstn_i    (rstn),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.awaddr_i  (awaddr),
		.wvalid_i  (wvalid),
		.wready_o  (wready),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.bvalid_o  (bvalid),
		.bready_i  (bready),
		.bresp_o   (bresp),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.araddr_i  (araddr),
		.rvalid_o  (rvalid),
		.rready_i  (rready),
		.rdata_o   (rdata),
		.rresp_o   (rresp),
		.mtip_o    (mtip),
		.msip_o    (msip)
	);

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles in test %s", cycle, cur_test);
			$display("Something failed");
			$finish;
		end
	end

	task automatic report_fault(input string msg);
		$display("%s: %s", cur_test, msg);
		errors++;
	endtask

	task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("** Error %s: %s expected %0h actual %0h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	// reads may be accepted from the first cycle out of reset
	a_reset_quiet: assert property (@(posedge clock)
		(cycle != 0 && (rstn || $past(rstn))) |->
		!bvalid && !rvalid && !awready && !wready && !mtip && !msip)
		else report_fault("valid, ready or interrupt active in or right after reset");
	a_reset_arready: assert property (@(posedge clock)
		(cycle != 0 && rstn) |-> !arready)
		else report_fault("arready high while reset is held");
	a_b_hold: assert property (@(posedge clock) disable iff (rstn)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else report_fault("write response dropped or changed before bready");
	a_r_hold: assert property (@(posedge clock) disable iff (rstn)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else report_fault("read response dropped or changed before rready");
	a_one_inflight: assert property (@(posedge clock) disable iff (rstn)
		(bvalid || rvalid) |-> !awready && !wready && !arready)
		else report_fault("new request accepted while a response is pending");
	a_msip_set: assert property (@(posedge clock) disable iff (rstn)
		awvalid && awready && awaddr == OFF_MSIP && wstrb[0] |=> msip == $past(wdata[0]))
		else report_fault("msip_o did not follow the strobed write");
	a_msip_keep: assert property (@(posedge clock) disable iff (rstn)
		awvalid && awready && awaddr == OFF_MSIP && !wstrb[0] |=> $stable(msip))
		else report_fault("msip_o changed on a write without strobe bit 0");

	task automatic start_test(input string name);
		cur_test     = name;
		errs_at_test = errors;
	endtask

	task automatic end_test();
		if (errors == errs_at_test) begin
			tests_passed++;
			$display("test %s passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, errors - errs_at_test);
		end
	endtask

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	// random back-pressure, optionally with competing requests
	task automatic complete_response(input bit is_rd);
		int unsigned hold;
		hold = $urandom % 8;
		if (poke_en) begin
			arvalid = 1'b1;
			araddr  = OFF_MTIME_LO;
			awvalid = 1'b1;
			wvalid  = 1'b1;
			awaddr  = OFF_MSIP;
			wdata   = 32'h1;
			wstrb   = 4'hF;
		end
		repeat (hold) step();
		if (is_rd)
			rready = 1'b1;
		else
			bready = 1'b1;
		step();
		rready  = 1'b0;
		bready  = 1'b0;
		arvalid = 1'b0;
		awvalid = 1'b0;
		wvalid  = 1'b0;
	endtask

	task automatic write_reg(
		input  logic [CLINT_ADDR_W-1:0] addr,
		input  logic [AXIL_DATA_W-1:0]  data,
		input  logic [AXIL_STRB_W-1:0]  strb,
		output axil_resp_t              resp,
		output int unsigned             acc
	);
		awvalid = 1'b1;
		wvalid  = 1'b1;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		// ready is judged on the edge itself, before the state moves
		@(posedge clock);
		while (!(awready && wready))
			@(posedge clock);
		acc = cycle;
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid) step();
		resp = bresp;
		complete_response(1'b0);
	endtask

	task automatic read_reg(
		input  logic [CLINT_ADDR_W-1:0] addr,
		output logic [AXIL_DATA_W-1:0]  data,
		output axil_resp_t              resp,
		output int unsigned             acc
	);
		arvalid = 1'b1;
		araddr  = addr;
		@(posedge clock);
		while (!arready)
			@(posedge clock);
		acc = cycle;
		#1;
		arvalid = 1'b0;
		while (!rvalid) step();
		data = rdata;
		resp = rresp;
		complete_response(1'b1);
	endtask

	task automatic write_check(
		input logic [CLINT_ADDR_W-1:0] addr,
		input logic [AXIL_DATA_W-1:0]  data,
		input logic [AXIL_STRB_W-1:0]  strb,
		input axil_resp_t              exp_resp
	);
		axil_resp_t  resp;
		int unsigned acc;
		write_reg(addr, data, strb, resp, acc);
		check_value("bresp", exp_resp, resp);
	endtask

	task automatic read_check(
		input logic [CLINT_ADDR_W-1:0] addr,
		input logic [AXIL_DATA_W-1:0]  exp_data,
		input axil_resp_t              exp_resp
	);
		logic [AXIL_DATA_W-1:0] data;
		axil_resp_t             resp;
		int unsigned            acc;
		read_reg(addr, data, resp, acc);
		check_value("rdata", exp_data, data);
		check_value("rresp", exp_resp, resp);
	endtask

	initial begin
		logic [AXIL_DATA_W-1:0] d0;
		logic [AXIL_DATA_W-1:0] d1;
		axil_resp_t             rs;
		int unsigned            c0;
		int unsigned            c1;
		void'($urandom(65));
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		arvalid = 1'b0;
		rready  = 1'b0;
		awaddr  = '0;
		araddr  = '0;
		wdata   = '0;
		wstrb   = '0;

		start_test("reset");
		wait (rstn === 1'b0);
		step();
		check_value("mtip_o", 0, mtip);
		check_value("msip_o", 0, msip);
		check_value("bvalid/rvalid", 0, {bvalid, rvalid});
		end_test();

		// mtime is sampled on the AR handshake edge
		start_test("counter");
		repeat (3) begin
			read_reg(OFF_MTIME_LO, d0, rs, c0);
			repeat ($urandom % 5) step();
			read_reg(OFF_MTIME_LO, d1, rs, c1);
			check_value("mtime step", c1 - c0, d1 - d0);
		end
		end_test();

		start_test("msip");
		write_check(OFF_MSIP, 32'h1, 4'hF, RESP_OKAY);
		check_value("msip_o", 1, msip);
		read_check(OFF_MSIP, 32'h1, RESP_OKAY);
		write_check(OFF_MSIP, 32'h0, 4'hE, RESP_OKAY);
		read_check(OFF_MSIP, 32'h1, RESP_OKAY);
		write_check(OFF_MSIP, 32'h0, 4'hF, RESP_OKAY);
		check_value("msip_o", 0, msip);
		read_check(OFF_MSIP, 32'h0, RESP_OKAY);
		end_test();

		// compare set ahead of mtime, then mtime moved just below it
		start_test("timer");
		write_check(OFF_MTIME_HI, 32'h0, 4'hF, RESP_OKAY);
		write_check(OFF_MTIMECMP_LO, CMP_BASE + CMP_STEPS, 4'hF, RESP_OKAY);
		write_check(OFF_MTIMECMP_HI, 32'h0, 4'hF, RESP_OKAY);
		check_value("mtip_o", 0, mtip);
		write_reg(OFF_MTIME_LO, CMP_BASE, 4'hF, rs, c0);
		while (cycle - c0 - 1 <= CMP_STEPS + 2) begin
			check_value("mtip_o", (cycle - c0 - 1) >= CMP_STEPS, mtip);
			step();
		end
		write_check(OFF_MTIMECMP_HI, 32'hFFFF_FFFF, 4'hF, RESP_OKAY);
		check_value("mtip_o", 0, mtip);
		end_test();

		start_test("unmapped");
		read_check(16'h0008, 32'h0, RESP_SLVERR);
		read_check(16'h1234, 32'h0, RESP_SLVERR);
		write_check(16'h0008, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR);
		write_check(16'h4008, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR);
		write_check(16'hBFF0, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR);
		read_check(OFF_MSIP, 32'h0, RESP_OKAY);
		read_check(OFF_MTIMECMP_LO, CMP_BASE + CMP_STEPS, RESP_OKAY);
		read_check(OFF_MTIMECMP_HI, 32'hFFFF_FFFF, RESP_OKAY);
		check_value("msip_o", 0, msip);
		end_test();

		start_test("backpressure");
		poke_en = 1'b1;
		for (int i = 0; i < 8; i++) begin
			write_check(OFF_MSIP, i % 2, 4'hF, RESP_OKAY);
			read_check(OFF_MSIP, i % 2, RESP_OKAY);
			read_check(OFF_MTIMECMP_LO, CMP_BASE + CMP_STEPS, RESP_OKAY);
		end
		poke_en = 1'b0;
		end_test();

		repeat (2) step();
		$display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
source/axil_pkg.sv
source/clint_pkg.sv
source/clint_delay_lfsr.sv
source/clint_regs.sv
source/clint_bus_ctrl.sv
source/clint_top.sv
tests/tb_clock_gen.sv
tests/clint_tb.sv

//--- Bender.yml
package:
  name: clint

sources:
  - source/axil_pkg.sv
  - source/clint_pkg.sv
  - source/clint_delay_lfsr.sv
  - source/clint_regs.sv
  - source/clint_bus_ctrl.sv
  - source/clint_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/clint_tb.sv
